/* compile.f */
common/dma_pkg.sv
logic/sync_fifo.sv
logic/wb_arbiter.sv
dma/dma_read_fsm.sv
dma/dma_write_fsm.sv
logic/dma_top.sv
verif/wb_mem_model.sv
verif/dma_tb.sv

/* Makefile */
# Verilator build and run for the DMA engine testbench

VERILATOR ?= verilator
TOP       ?= dma_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAILED
PASS_MSG  ?= TEST PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/dma_tb.sv */
/* dma engine testbench
   pushes copy descriptors and checks destination memory against a reference copy */
`timescale 1ns/100ps

module dma_tb;
   import dma_pkg::*;

   localparam logic [ADDR_W-1:0] POISON = 16'hf000;
   localparam int RAND_N = 8;
   // short, multi-burst, six queued, random worst case, error run
   localparam int TOTAL_WORDS = 5 + 37 + 61 + RAND_N * 64 + 10;
   localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 2000;

   logic              clk = 1'b0;
   logic              reset_n;
   logic              desc_push;
   logic [ADDR_W-1:0] desc_src;
   logic [ADDR_W-1:0] desc_dst;
   logic [LEN_W-1:0]  desc_len;
   logic              desc_full;
   logic              m_cyc;
   logic              m_stb;
   logic              m_we;
   logic [ADDR_W-1:0] m_adr;
   logic [31:0]       m_dat_w;
   logic [31:0]       m_dat_r;
   logic              m_ack;
   logic              m_err;
   logic              busy;
   logic              error;
   logic [15:0]       descriptor_count;
   rd_state_t         rd_state;

   logic [31:0] expect_img [logic [ADDR_W-1:0]];
   int unsigned q_src[$];
   int unsigned q_dst[$];
   int unsigned q_len[$];
   int          six_len[6] = '{3, 9, 16, 1, 12, 20};
   int          cycles = 0;
   int          errors = 0;
   int          tests = 0;
   int          failed = 0;
   logic        check_pending = 1'b0;

   always #20 clk = ~clk;

   dma_top #(.DATA_W(32), .BURST_LEN(8), .FIFO_DEPTH(16), .DESC_DEPTH(4)) dut_i (.*);

   wb_mem_model #(.DATA_W(32), .POISON_ADR(POISON)) mem_i (
      .clk(clk), .reset_n(reset_n), .cyc(m_cyc), .stb(m_stb), .we(m_we), .adr(m_adr),
      .dat_w(m_dat_w), .dat_r(m_dat_r), .ack(m_ack), .err(m_err)
   );

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   // snapshot the regions, then replay the copies in queue order
   function automatic void build_expected();
      expect_img.delete();
      foreach (q_src[i]) begin
         for (int a = int'(q_src[i]); a < int'(q_src[i] + q_len[i]); a++)
            expect_img[ADDR_W'(a)] = mem_i.peek(ADDR_W'(a));
         for (int a = int'(q_dst[i]) - 2; a < int'(q_dst[i] + q_len[i]) + 2; a++)
            expect_img[ADDR_W'(a)] = mem_i.peek(ADDR_W'(a));
      end
      foreach (q_src[i])
         for (int unsigned k = 0; k < q_len[i]; k++)
            expect_img[ADDR_W'(q_dst[i] + k)] = expect_img[ADDR_W'(q_src[i] + k)];
   endfunction

   always @(posedge clk) begin
      if (check_pending) begin
         foreach (expect_img[a]) begin
            assert (mem_i.peek(a) === expect_img[a]) else begin
               $display("error mem[%h] expected %h got %h", a, expect_img[a], mem_i.peek(a));
               errors++;
            end
         end
         check_pending = 1'b0;
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic add_desc(input int unsigned src, input int unsigned dst, input int unsigned len);
      q_src.push_back(src);
      q_dst.push_back(dst);
      q_len.push_back(len);
      for (int unsigned k = 0; k < len; k++)
         mem_i.poke(ADDR_W'(src + k), $urandom());
   endtask

   task automatic push_desc(input int unsigned src, input int unsigned dst, input int unsigned len);
      while (desc_full) next_cycle();
      desc_src  = ADDR_W'(src);
      desc_dst  = ADDR_W'(dst);
      desc_len  = LEN_W'(len);
      desc_push = 1'b1;
      next_cycle();
      desc_push = 1'b0;
   endtask

   task automatic report(input string name, input int start_errors);
      tests++;
      if (errors == start_errors) begin
         $display("test %s: ok", name);
      end else begin
         failed++;
         $display("test %s: %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic run_copies(input string name);
      int target;
      int start_errors;
      start_errors = errors;
      target = int'(descriptor_count) + q_src.size();
      build_expected();
      foreach (q_src[i]) push_desc(q_src[i], q_dst[i], q_len[i]);
      while (int'(descriptor_count) < target || busy) next_cycle();
      check_pending = 1'b1;
      wait (!check_pending);
      #2;
      assert (descriptor_count == 16'(target)) else begin
         $display("error descriptor_count expected %h got %h", 16'(target), descriptor_count);
         errors++;
      end
      report(name, start_errors);
      q_src.delete();
      q_dst.delete();
      q_len.delete();
   endtask

   task automatic read_error_run();
      logic [15:0] start_count;
      int          start_errors;
      start_count = descriptor_count;
      start_errors = errors;
      push_desc(POISON - 3, 16'h9000, 10);
      while (!error) next_cycle();
      // words fetched before the fault still drain to memory
      while (m_cyc) next_cycle();
      repeat (50) begin
         assert (!m_cyc) else begin
            $display("error m_cyc expected 0 got %h", m_cyc);
            errors++;
         end
         next_cycle();
      end
      assert (rd_state == RD_ERROR) else begin
         $display("error rd_state expected %h got %h", RD_ERROR, rd_state);
         errors++;
      end
      assert (descriptor_count == start_count) else begin
         $display("error descriptor_count expected %h got %h", start_count, descriptor_count);
         errors++;
      end
      reset_n = 1'b0;
      repeat (3) next_cycle();
      reset_n = 1'b1;
      assert (!error) else begin
         $display("error error expected 0 got %h", error);
         errors++;
      end
      assert (!busy) else begin
         $display("error busy expected 0 got %h", busy);
         errors++;
      end
      assert (rd_state == RD_IDLE) else begin
         $display("error rd_state expected %h got %h", RD_IDLE, rd_state);
         errors++;
      end
      report("read error", start_errors);
   endtask

   initial begin
      void'($urandom(70997));
      reset_n   = 1'b0;
      desc_push = 1'b0;
      desc_src  = '0;
      desc_dst  = '0;
      desc_len  = '0;
      repeat (3) @(posedge clk);
      #2;
      reset_n = 1'b1;
      add_desc(16'h0100, 16'h0200, 5);
      run_copies("short copy");
      add_desc(16'h0400, 16'h0800, 37);
      run_copies("multi-burst copy");
      for (int i = 0; i < 6; i++)
         add_desc(16'h1000 + i * 16'h40, 16'h2000 + i * 16'h40, six_len[i]);
      run_copies("queued descriptors");
      // disjoint 256-word slots keep source and destination apart
      for (int i = 0; i < RAND_N; i++)
         add_desc(16'h3000 + i * 16'h100 + $urandom_range(31, 0),
                  16'h6000 + i * 16'h100 + $urandom_range(31, 0), $urandom_range(64, 1));
      run_copies("random latency");
      read_error_run();
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verif/wb_mem_model.sv */
/* wishbone classic slave memory
   sparse word store with random ack delay and a read error at one address */
`timescale 1ns/100ps

module wb_mem_model
   import dma_pkg::*;
#(
   parameter int                DATA_W     = 32,
   parameter logic [ADDR_W-1:0] POISON_ADR = 16'hf000
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [ADDR_W-1:0] adr,
   input  logic [DATA_W-1:0] dat_w,
   output logic [DATA_W-1:0] dat_r,
   output logic              ack,
   output logic              err
);

   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
   int unsigned       wait_left;

   // unwritten words read back as a pattern of their address
   function automatic logic [DATA_W-1:0] peek(input logic [ADDR_W-1:0] a);
      if (mem.exists(a)) return mem[a];
      return DATA_W'({~a, a ^ 16'hc3a5});
   endfunction

   function automatic void poke(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      mem[a] = d;
   endfunction

   always @(posedge clk) begin
      ack <= 1'b0;
      err <= 1'b0;
      if (!reset_n) begin
         wait_left <= 0;
      end else if (cyc && stb && !ack && !err) begin
         if (wait_left != 0) begin
            wait_left <= wait_left - 1;
         end else begin
            // idle cycles before the next answer
            wait_left <= $urandom_range(3, 0);
            if (!we && adr == POISON_ADR) begin
               err <= 1'b1;
            end else begin
               ack <= 1'b1;
               if (we) mem[adr] = dat_w;
               else    dat_r <= peek(adr);
            end
         end
      end
   end

endmodule

/* logic/dma_top.sv */
/* memory-to-memory DMA engine top
   descriptor queue, data FIFO, read and write FSMs and the bus arbiter */
`timescale 1ns/100ps

module dma_top
   import dma_pkg::*;
#(
   parameter int DATA_W     = 32,
   parameter int BURST_LEN  = 8,
   parameter int FIFO_DEPTH = 16,
   parameter int DESC_DEPTH = 4
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              desc_push,
   input  logic [ADDR_W-1:0] desc_src,
   input  logic [ADDR_W-1:0] desc_dst,
   input  logic [LEN_W-1:0]  desc_len,
   output logic              desc_full,
   output logic              m_cyc,
   output logic              m_stb,
   output logic              m_we,
   output logic [ADDR_W-1:0] m_adr,
   output logic [DATA_W-1:0] m_dat_w,
   input  logic [DATA_W-1:0] m_dat_r,
   input  logic              m_ack,
   input  logic              m_err,
   output logic              busy,
   output logic              error,
   output logic [15:0]       descriptor_count,
   output rd_state_t         rd_state
);

   logic [DESC_W-1:0] desc_in, desc_head;
   logic              desc_empty, desc_valid, desc_pop;
   logic [ADDR_W-1:0] head_src, head_dst;
   logic [LEN_W-1:0]  head_len;
   logic                            fifo_wr_en, fifo_rd_en, fifo_empty;
   logic [DATA_W-1:0]               fifo_wr_data, fifo_rd_data;
   logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
   logic              rd_cyc, rd_stb, rd_ack, rd_err;
   logic [ADDR_W-1:0] rd_adr, wr_adr;
   logic [DATA_W-1:0] rd_dat_r, wr_dat_w;
   logic              wr_cyc, wr_stb, wr_we, wr_ack, wr_done;

   // descriptor packed as {src, dst, len}
   assign desc_in = {desc_src, desc_dst, desc_len};
   assign {head_src, head_dst, head_len} = desc_head;
   assign desc_valid = !desc_empty;

   sync_fifo #(.WIDTH(DESC_W), .DEPTH(DESC_DEPTH)) desc_fifo_i (
      .clk(clk), .reset_n(reset_n),
      .push(desc_push), .push_data(desc_in),
      .pop(desc_pop), .pop_data(desc_head),
      .empty(desc_empty), .full(desc_full), .count()
   );

   sync_fifo #(.WIDTH(DATA_W), .DEPTH(FIFO_DEPTH)) data_fifo_i (
      .clk(clk), .reset_n(reset_n),
      .push(fifo_wr_en), .push_data(fifo_wr_data),
      .pop(fifo_rd_en), .pop_data(fifo_rd_data),
      .empty(fifo_empty), .full(), .count(fifo_count)
   );

   dma_read_fsm #(.DATA_W(DATA_W), .BURST_LEN(BURST_LEN), .FIFO_DEPTH(FIFO_DEPTH)) read_fsm_i (
      .clk(clk), .reset_n(reset_n),
      .desc_valid(desc_valid), .desc_src(head_src), .desc_len(head_len),
      .wr_done(wr_done), .desc_pop(desc_pop),
      .fifo_wr_en(fifo_wr_en), .fifo_wr_data(fifo_wr_data), .fifo_count(fifo_count),
      .rd_cyc(rd_cyc), .rd_stb(rd_stb), .rd_adr(rd_adr),
      .rd_dat_r(rd_dat_r), .rd_ack(rd_ack), .rd_err(rd_err),
      .state(rd_state), .busy(busy), .error(error),
      .descriptor_count(descriptor_count)
   );

   dma_write_fsm #(.DATA_W(DATA_W)) write_fsm_i (
      .clk(clk), .reset_n(reset_n),
      .desc_valid(desc_valid), .desc_dst(head_dst), .desc_len(head_len),
      .fifo_rd_en(fifo_rd_en), .fifo_rd_data(fifo_rd_data), .fifo_empty(fifo_empty),
      .wr_cyc(wr_cyc), .wr_stb(wr_stb), .wr_we(wr_we), .wr_adr(wr_adr),
      .wr_dat_w(wr_dat_w), .wr_ack(wr_ack), .wr_done(wr_done)
   );

   wb_arbiter #(.DATA_W(DATA_W)) arbiter_i (
      .clk(clk), .reset_n(reset_n),
      .rd_cyc(rd_cyc), .rd_stb(rd_stb), .rd_adr(rd_adr),
      .rd_dat_r(rd_dat_r), .rd_ack(rd_ack), .rd_err(rd_err),
      .wr_cyc(wr_cyc), .wr_stb(wr_stb), .wr_we(wr_we), .wr_adr(wr_adr),
      .wr_dat_w(wr_dat_w), .wr_ack(wr_ack),
      .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we), .m_adr(m_adr), .m_dat_w(m_dat_w),
      .m_dat_r(m_dat_r), .m_ack(m_ack), .m_err(m_err)
   );

endmodule

/* dma/dma_write_fsm.sv */
/* dma write-destination FSM
   drains the data FIFO to the destination and signals the finished descriptor */
`timescale 1ns/100ps

module dma_write_fsm
   import dma_pkg::*;
#(
   parameter int DATA_W = 32
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              desc_valid,
   input  logic [ADDR_W-1:0] desc_dst,
   input  logic [LEN_W-1:0]  desc_len,
   output logic              fifo_rd_en,
   input  logic [DATA_W-1:0] fifo_rd_data,
   input  logic              fifo_empty,
   output logic              wr_cyc,
   output logic              wr_stb,
   output logic              wr_we,
   output logic [ADDR_W-1:0] wr_adr,
   output logic [DATA_W-1:0] wr_dat_w,
   input  logic              wr_ack,
   output logic              wr_done
);

   wr_state_t         state;
   wr_state_t         next;
   logic [ADDR_W-1:0] dst_addr;
   logic [LEN_W-1:0]  words_left;

   always_ff @(posedge clk) begin
      if (!reset_n) state <= WR_IDLE;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         WR_IDLE: if (desc_valid) next = WR_BUS;
         WR_BUS:  if (wr_ack && words_left == LEN_W'(1)) next = WR_DONE;
         // single cycle, the reader pops the head on this pulse
         WR_DONE: next = WR_IDLE;
         default: next = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == WR_IDLE && desc_valid) begin
         dst_addr   <= desc_dst;
         words_left <= desc_len;
      end
      if (fifo_rd_en) begin
         dst_addr   <= dst_addr + 1'b1;
         words_left <= words_left - 1'b1;
      end
   end

   // only this side pops, so a non-empty FIFO stays non-empty until ack
   assign wr_cyc     = (state == WR_BUS) && !fifo_empty;
   assign wr_stb     = wr_cyc;
   assign wr_we      = wr_stb;
   assign wr_adr     = dst_addr;
   assign wr_dat_w   = fifo_rd_data;
   assign fifo_rd_en = wr_cyc && wr_ack;
   assign wr_done    = (state == WR_DONE);

endmodule

/* dma/dma_read_fsm.sv */
/* dma read-source FSM
   fetches source words in bursts under one cyc and fills the data FIFO */
`timescale 1ns/100ps

module dma_read_fsm
   import dma_pkg::*;
#(
   parameter int DATA_W     = 32,
   parameter int BURST_LEN  = 8,
   parameter int FIFO_DEPTH = 16
)(
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           desc_valid,
   input  logic [ADDR_W-1:0]              desc_src,
   input  logic [LEN_W-1:0]               desc_len,
   input  logic                           wr_done,
   output logic                           desc_pop,
   output logic                           fifo_wr_en,
   output logic [DATA_W-1:0]              fifo_wr_data,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
   output logic                           rd_cyc,
   output logic                           rd_stb,
   output logic [ADDR_W-1:0]              rd_adr,
   input  logic [DATA_W-1:0]              rd_dat_r,
   input  logic                           rd_ack,
   input  logic                           rd_err,
   output rd_state_t                      state,
   output logic                           busy,
   output logic                           error,
   output logic [15:0]                    descriptor_count
);

   localparam int BST_W = $clog2(BURST_LEN + 1);

   rd_state_t         next;
   logic [ADDR_W-1:0] src_addr;
   logic [LEN_W-1:0]  words_left;
   logic [BST_W-1:0]  burst_left;
   logic [LEN_W-1:0]  free_words;
   logic [LEN_W-1:0]  burst_size;
   logic              last_beat;

   assign free_words = LEN_W'(FIFO_DEPTH) - LEN_W'(fifo_count);
   assign last_beat  = rd_ack && (burst_left == BST_W'(1));

   // lesser of burst limit, words remaining and FIFO room
   always_comb begin
      burst_size = LEN_W'(BURST_LEN);
      if (words_left < burst_size) burst_size = words_left;
      if (free_words < burst_size) burst_size = free_words;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) state <= RD_IDLE;
      else          state <= next;
   end

   always_comb begin
      next = state;
      unique case (state)
         RD_IDLE:    if (desc_valid) next = RD_ADDR;
         // no room means cyc stays low until the writer drains a word
         RD_ADDR:    if (free_words != '0) next = RD_DATA;
         RD_DATA: begin
            if (rd_err)
               next = RD_ERROR;
            else if (last_beat)
               next = (words_left == LEN_W'(1)) ? RD_WAIT_WR : RD_ADDR;
         end
         RD_WAIT_WR: if (wr_done) next = RD_IDLE;
         RD_ERROR:   next = RD_ERROR;
         default:    next = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == RD_IDLE && desc_valid) begin
         src_addr   <= desc_src;
         words_left <= desc_len;
      end
      if (state == RD_ADDR) burst_left <= BST_W'(burst_size);
      if (state == RD_DATA && rd_ack) begin
         src_addr   <= src_addr + 1'b1;
         words_left <= words_left - 1'b1;
         burst_left <= burst_left - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n)      descriptor_count <= '0;
      else if (desc_pop) descriptor_count <= descriptor_count + 1'b1;
   end

   assign rd_cyc       = (state == RD_DATA);
   assign rd_stb       = rd_cyc;
   assign rd_adr       = src_addr;
   assign fifo_wr_en   = rd_cyc && rd_ack;
   assign fifo_wr_data = rd_dat_r;
   assign desc_pop     = (state == RD_WAIT_WR) && wr_done;
   assign busy         = (state != RD_IDLE);
   assign error        = (state == RD_ERROR);

   // a pending read keeps its strobe and address until answered
   a_stb_hold: assert property (@(posedge clk) disable iff (!reset_n)
      rd_stb && !rd_ack && !rd_err |=> rd_stb && $stable(rd_adr));

   a_len_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
      state == RD_IDLE && desc_valid |-> desc_len != '0);

endmodule

/* logic/wb_arbiter.sv */
/* wishbone classic arbiter
   round-robin join of the read and write masters onto one port */
`timescale 1ns/100ps

module wb_arbiter
   import dma_pkg::*;
#(
   parameter int DATA_W = 32
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              rd_cyc,
   input  logic              rd_stb,
   input  logic [ADDR_W-1:0] rd_adr,
   output logic [DATA_W-1:0] rd_dat_r,
   output logic              rd_ack,
   output logic              rd_err,
   input  logic              wr_cyc,
   input  logic              wr_stb,
   input  logic              wr_we,
   input  logic [ADDR_W-1:0] wr_adr,
   input  logic [DATA_W-1:0] wr_dat_w,
   output logic              wr_ack,
   output logic              m_cyc,
   output logic              m_stb,
   output logic              m_we,
   output logic [ADDR_W-1:0] m_adr,
   output logic [DATA_W-1:0] m_dat_w,
   input  logic [DATA_W-1:0] m_dat_r,
   input  logic              m_ack,
   input  logic              m_err
);

   bus_owner_t owner;
   bus_owner_t last_owner;
   logic       held;
   logic       last_cyc;

   assign last_cyc = (last_owner == OWN_RD) ? rd_cyc : wr_cyc;

   always_comb begin
      owner = last_owner;
      if (!(held && last_cyc)) begin
         // favour whoever did not have the last tenure
         if (last_owner == OWN_WR) owner = rd_cyc ? OWN_RD : (wr_cyc ? OWN_WR : last_owner);
         else                      owner = wr_cyc ? OWN_WR : (rd_cyc ? OWN_RD : last_owner);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         last_owner <= OWN_WR;
         held       <= 1'b0;
      end else begin
         if (m_cyc) last_owner <= owner;
         held <= m_cyc;
      end
   end

   assign m_cyc   = (owner == OWN_RD) ? rd_cyc : wr_cyc;
   assign m_stb   = (owner == OWN_RD) ? rd_stb : wr_stb;
   assign m_we    = (owner == OWN_WR) && wr_we;
   assign m_adr   = (owner == OWN_RD) ? rd_adr : wr_adr;
   assign m_dat_w = (owner == OWN_WR) ? wr_dat_w : '0;

   assign rd_dat_r = m_dat_r;
   assign rd_ack   = (owner == OWN_RD) && rd_cyc && m_ack;
   assign rd_err   = (owner == OWN_RD) && rd_cyc && m_err;
   assign wr_ack   = (owner == OWN_WR) && wr_cyc && m_ack;

   a_rd_keeps_bus: assert property (@(posedge clk) disable iff (!reset_n)
      owner == OWN_RD && rd_cyc |=> !rd_cyc || owner == OWN_RD);
   a_wr_keeps_bus: assert property (@(posedge clk) disable iff (!reset_n)
      owner == OWN_WR && wr_cyc |=> !wr_cyc || owner == OWN_WR);

endmodule

/* logic/sync_fifo.sv */
/* synchronous FIFO
   circular buffer with occupancy count and the head word on pop_data */
`timescale 1ns/100ps

module sync_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
)(
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         push,
   input  logic [WIDTH-1:0]             push_data,
   input  logic                         pop,
   output logic [WIDTH-1:0]             pop_data,
   output logic                         empty,
   output logic                         full,
   output logic [$clog2(DEPTH+1)-1:0]   count
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;
   assign empty    = (count == '0);
   assign full     = (count == DEPTH);
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n) !(push && full));
   a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n) !(pop && empty));

endmodule

/* common/dma_pkg.sv */
/* dma shared definitions
   descriptor field widths and the state and bus-owner encodings */
package dma_pkg;

   // word address and length widths
   localparam int ADDR_W = 16;
   localparam int LEN_W  = 12;

   // packed descriptor is {src, dst, len}
   localparam int DESC_W = 2 * ADDR_W + LEN_W;

   // read-source machine
   typedef enum logic [2:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA,
      RD_WAIT_WR,
      RD_ERROR
   } rd_state_t;

   // write-destination machine
   typedef enum logic [1:0] {
      WR_IDLE,
      WR_BUS,
      WR_DONE
   } wr_state_t;

   // which master holds the shared wishbone port
   typedef enum logic {
      OWN_RD,
      OWN_WR
   } bus_owner_t;

endpackage
